// File: src/mod_seq_pkg.sv
// Shared encodings for the microcoded modular-arithmetic engine.
// The micro-op line is 12 bits wide and has two views (control and arithmetic).
// Datapath width and modulus are module parameters. They are not defined here.
package mod_seq_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int INSTR_W    = 12;
    localparam int PC_W       = 5;
    localparam int REG_ADDR_W = 3;

    // ----------------------------------------------------------------------
    // field encodings
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        UOP_IDLE = 2'd0,
        UOP_WR   = 2'd1,
        UOP_RD   = 2'd2,
        UOP_OP   = 2'd3
    } uop_kind_e;

    typedef enum logic {
        ARITH_ADD = 1'b0,
        ARITH_MUL = 1'b1
    } arith_cmd_e;

    // operand ids in write lines, result ids in read lines
    typedef enum logic [3:0] {
        ID_ZERO  = 4'd0,
        ID_ONE   = 4'd1,
        ID_A     = 4'd2,
        ID_B     = 4'd3,
        ID_C     = 4'd4,
        ID_RES_R = 4'd8,
        ID_RES_S = 4'd9
    } opnd_id_e;

    typedef enum logic [1:0] {
        CMD_NONE    = 2'd0,
        CMD_MAC     = 2'd1,
        CMD_SQR_ADD = 2'd2,
        CMD_RSVD    = 2'd3
    } cmd_e;

    // ----------------------------------------------------------------------
    // micro-op line
    // ----------------------------------------------------------------------
    typedef struct packed {
        uop_kind_e             kind;
        opnd_id_e              id;
        logic [REG_ADDR_W-1:0] addr;
        logic [2:0]            pad;
    } uop_ctrl_t;

    typedef struct packed {
        uop_kind_e             kind;
        arith_cmd_e            cmd;
        logic [REG_ADDR_W-1:0] dst;
        logic [REG_ADDR_W-1:0] src_a;
        logic [REG_ADDR_W-1:0] src_b;
    } uop_arith_t;

    typedef union packed {
        uop_ctrl_t  ctrl;
        uop_arith_t arith;
    } uop_line_u;

    // program entry points
    localparam logic [PC_W-1:0] PC_IDLE      = 5'd0;
    localparam logic [PC_W-1:0] PC_MAC_START = 5'd1;
    localparam logic [PC_W-1:0] PC_SQR_START = 5'd9;

endpackage

// File: src/uop_rom.sv
// Program store, combinational from the program counter.
// Address 0 is the idle line; each program ends on an idle-kind line.
// Unused addresses read as idle lines.
module uop_rom (
    input  logic [mod_seq_pkg::PC_W-1:0] pc_i,
    output mod_seq_pkg::uop_line_u       line_o
);
    import mod_seq_pkg::*;

    function automatic uop_line_u wr_line(input opnd_id_e src,
                                          input logic [REG_ADDR_W-1:0] dst);
        uop_line_u l;
        l.ctrl = '{kind: UOP_WR, id: src, addr: dst, pad: 3'b000};
        return l;
    endfunction

    function automatic uop_line_u rd_line(input opnd_id_e res,
                                          input logic [REG_ADDR_W-1:0] src);
        uop_line_u l;
        l.ctrl = '{kind: UOP_RD, id: res, addr: src, pad: 3'b000};
        return l;
    endfunction

    function automatic uop_line_u op_line(input arith_cmd_e cmd,
                                          input logic [REG_ADDR_W-1:0] dst,
                                          input logic [REG_ADDR_W-1:0] a,
                                          input logic [REG_ADDR_W-1:0] b);
        uop_line_u l;
        l.arith = '{kind: UOP_OP, cmd: cmd, dst: dst, src_a: a, src_b: b};
        return l;
    endfunction

    always_comb begin
        line_o = '0;
        case (pc_i)
            // mac: r3 = a*b, r4 = r3 + c
            5'd1:  line_o = wr_line(ID_A, 3'd0);
            5'd2:  line_o = wr_line(ID_B, 3'd1);
            5'd3:  line_o = wr_line(ID_C, 3'd2);
            5'd4:  line_o = op_line(ARITH_MUL, 3'd3, 3'd0, 3'd1);
            5'd5:  line_o = op_line(ARITH_ADD, 3'd4, 3'd3, 3'd2);
            5'd6:  line_o = rd_line(ID_RES_R, 3'd4);
            5'd7:  line_o = rd_line(ID_RES_S, 3'd3);
            // square and add: r2 = a*a, r3 = a + b
            5'd9:  line_o = wr_line(ID_A, 3'd0);
            5'd10: line_o = wr_line(ID_B, 3'd1);
            5'd11: line_o = op_line(ARITH_MUL, 3'd2, 3'd0, 3'd0);
            5'd12: line_o = op_line(ARITH_ADD, 3'd3, 3'd0, 3'd1);
            5'd13: line_o = rd_line(ID_RES_R, 3'd2);
            5'd14: line_o = rd_line(ID_RES_S, 3'd3);
            default: line_o = '0;
        endcase
    end

endmodule

// File: src/operand_bank.sv
// Operand capture and write-data select.
// Operands are latched only on an accepted start and must be below the modulus.
// Non-write lines drive zero onto the write data.
module operand_bank #(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    capture_i,
    input  logic [WIDTH-1:0]        opnd_a_i,
    input  logic [WIDTH-1:0]        opnd_b_i,
    input  logic [WIDTH-1:0]        opnd_c_i,
    input  mod_seq_pkg::uop_line_u  line_i,
    output logic [WIDTH-1:0]        wr_data_o
);
    import mod_seq_pkg::*;

    logic [WIDTH-1:0] opnd_a_q;
    logic [WIDTH-1:0] opnd_b_q;
    logic [WIDTH-1:0] opnd_c_q;

    always_ff @(posedge clk) begin
        if (capture_i) begin
            opnd_a_q <= opnd_a_i;
            opnd_b_q <= opnd_b_i;
            opnd_c_q <= opnd_c_i;
        end
    end

    // constant or captured operand for write lines
    always_comb begin
        wr_data_o = '0;
        if (line_i.ctrl.kind == UOP_WR) begin
            case (line_i.ctrl.id)
                ID_ZERO: wr_data_o = '0;
                ID_ONE:  wr_data_o = WIDTH'(1);
                ID_A:    wr_data_o = opnd_a_q;
                ID_B:    wr_data_o = opnd_b_q;
                ID_C:    wr_data_o = opnd_c_q;
                default: wr_data_o = '0;
            endcase
        end
    end

    // a capture must only land while the sequencer sits on an idle line
    a_capture_at_idle : assert property (@(posedge clk) disable iff (!reset_n)
        capture_i |-> (line_i.ctrl.kind == UOP_IDLE))
        else $error("operand capture while a program line is active");

endmodule

// File: src/uop_sequencer.sv
// Program counter FSM with a four-cycle issue spacing.
// Holds while the arithmetic unit is busy; the gap count restarts afterwards.
// Only CMD_MAC and CMD_SQR_ADD are dispatched, other commands are dropped.
module uop_sequencer (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  mod_seq_pkg::cmd_e             cmd_i,
    input  logic                          busy_i,
    input  mod_seq_pkg::uop_line_u        line_i,
    output logic [mod_seq_pkg::PC_W-1:0]  pc_o,
    output logic                          issue_o,
    output logic                          capture_o,
    output logic                          prog_end_o,
    output logic                          ready_o
);
    import mod_seq_pkg::*;

    logic [PC_W-1:0] pc_q;
    logic [1:0]      gap_q;
    logic            at_idle;
    logic            cmd_valid;
    logic            end_line;

    // ----------------------------------------------------------------------
    // status and strobes
    // ----------------------------------------------------------------------
    assign at_idle   = (pc_q == PC_IDLE);
    assign cmd_valid = (cmd_i == CMD_MAC) || (cmd_i == CMD_SQR_ADD);
    assign end_line  = (line_i.ctrl.kind == UOP_IDLE);

    assign ready_o    = at_idle && !busy_i;
    assign capture_o  = start_i && ready_o && cmd_valid;
    // one line every fourth cycle while a program runs
    assign issue_o    = !at_idle && !busy_i && (gap_q == 2'd3);
    assign prog_end_o = issue_o && end_line;
    assign pc_o       = pc_q;

    // ----------------------------------------------------------------------
    // program counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q  <= PC_IDLE;
            gap_q <= 2'd0;
        end else if (capture_o) begin
            // dispatch
            pc_q  <= (cmd_i == CMD_MAC) ? PC_MAC_START : PC_SQR_START;
            gap_q <= 2'd0;
        end else if (busy_i || at_idle) begin
            gap_q <= 2'd0;
        end else begin
            gap_q <= gap_q + 2'd1;
            if (issue_o) begin
                pc_q <= end_line ? PC_IDLE : pc_q + 1'b1;
            end
        end
    end

    // busy may only rise right after an issued multiply line
    a_busy_after_mul : assert property (@(posedge clk) disable iff (!reset_n)
        $rose(busy_i) |-> $past(issue_o && (line_i.arith.kind == UOP_OP)
                                && (line_i.arith.cmd == ARITH_MUL)))
        else $error("busy rose without an issued multiply line");

endmodule

// File: src/mod_arith_unit.sv
// Register file with modular add and a bit-serial modular multiply.
// All register contents must stay below PRIME, and PRIME must fit in WIDTH bits.
// A multiply takes WIDTH cycles with busy_o high; the add takes effect on issue.
module mod_arith_unit #(
    parameter int          WIDTH = 16,
    parameter int unsigned PRIME = 65521
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    issue_i,
    input  mod_seq_pkg::uop_line_u  line_i,
    input  logic [WIDTH-1:0]        wr_data_i,
    output logic [WIDTH-1:0]        rd_data_o,
    output logic                    busy_o
);
    import mod_seq_pkg::*;

    localparam int             CNT_W = $clog2(WIDTH + 1);
    localparam logic [WIDTH:0] P_EXT = (WIDTH + 1)'(PRIME);

    logic [WIDTH-1:0]      rf [2**REG_ADDR_W];
    logic                  busy_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [WIDTH-1:0]      mcand_q;
    logic [WIDTH-1:0]      mplier_q;
    logic [WIDTH-1:0]      acc_q;
    logic [REG_ADDR_W-1:0] mul_dst_q;

    logic             wr_issue;
    logic             add_issue;
    logic             mul_start;
    logic             mul_last;
    logic [WIDTH-1:0] src_a_val;
    logic [WIDTH-1:0] src_b_val;
    logic [WIDTH-1:0] add_res;
    logic [WIDTH-1:0] acc_dbl;
    logic [WIDTH-1:0] acc_next;

    // single conditional subtraction, input below 2*PRIME
    function automatic logic [WIDTH-1:0] fold(input logic [WIDTH:0] v);
        logic [WIDTH:0] r;
        r = (v >= P_EXT) ? v - P_EXT : v;
        return r[WIDTH-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------
    assign wr_issue  = issue_i && (line_i.ctrl.kind == UOP_WR);
    assign add_issue = issue_i && (line_i.arith.kind == UOP_OP)
                       && (line_i.arith.cmd == ARITH_ADD);
    assign mul_start = issue_i && (line_i.arith.kind == UOP_OP)
                       && (line_i.arith.cmd == ARITH_MUL);
    assign mul_last  = busy_q && (cnt_q == CNT_W'(1));

    assign src_a_val = rf[line_i.arith.src_a];
    assign src_b_val = rf[line_i.arith.src_b];
    assign add_res   = fold({1'b0, src_a_val} + {1'b0, src_b_val});

    // msb-first double and add
    assign acc_dbl  = fold({acc_q, 1'b0});
    assign acc_next = fold({1'b0, acc_dbl} + (mplier_q[WIDTH-1] ? {1'b0, mcand_q} : '0));

    assign rd_data_o = rf[line_i.ctrl.addr];
    assign busy_o    = busy_q;

    // ----------------------------------------------------------------------
    // multiply control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (mul_start) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(WIDTH);
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (mul_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // register file and multiply datapath
    always_ff @(posedge clk) begin
        if (wr_issue) begin
            rf[line_i.ctrl.addr] <= wr_data_i;
        end
        if (add_issue) begin
            rf[line_i.arith.dst] <= add_res;
        end
        if (mul_last) begin
            rf[mul_dst_q] <= acc_next;
        end
        if (mul_start) begin
            mcand_q   <= src_a_val;
            mplier_q  <= src_b_val;
            acc_q     <= '0;
            mul_dst_q <= line_i.arith.dst;
        end else if (busy_q) begin
            acc_q    <= acc_next;
            mplier_q <= mplier_q << 1;
        end
    end

    a_no_issue_busy : assert property (@(posedge clk) disable iff (!reset_n)
        busy_o |-> !issue_i)
        else $error("line issued while a multiply was running");

endmodule

// File: src/result_regs.sv
// Result registers with a valid level and a one-cycle done pulse.
// Results hold from done until the next accepted start.
module result_regs #(
    parameter int WIDTH = 16
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    issue_i,
    input  logic                    capture_i,
    input  logic                    prog_end_i,
    input  mod_seq_pkg::uop_line_u  line_i,
    input  logic [WIDTH-1:0]        rd_data_i,
    output logic [WIDTH-1:0]        result_r_o,
    output logic [WIDTH-1:0]        result_s_o,
    output logic                    valid_o,
    output logic                    done_o
);
    import mod_seq_pkg::*;

    logic rd_issue;

    assign rd_issue = issue_i && (line_i.ctrl.kind == UOP_RD);

    always_ff @(posedge clk) begin
        if (rd_issue && (line_i.ctrl.id == ID_RES_R)) begin
            result_r_o <= rd_data_i;
        end
        if (rd_issue && (line_i.ctrl.id == ID_RES_S)) begin
            result_s_o <= rd_data_i;
        end
    end

    // valid drops on a start, rises with done at program end
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= prog_end_i;
            if (capture_i) begin
                valid_o <= 1'b0;
            end else if (prog_end_i) begin
                valid_o <= 1'b1;
            end
        end
    end

endmodule

// File: src/mod_seq_top.sv
// Microcoded modular-arithmetic engine, top level.
// start_i is sampled only while ready_o is high; operands must be below PRIME.
// Latency to done_o depends on the number of multiplies in the program.
module mod_seq_top #(
    parameter int          WIDTH = 16,
    parameter int unsigned PRIME = 65521
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start_i,
    input  mod_seq_pkg::cmd_e cmd_i,
    input  logic [WIDTH-1:0]  opnd_a_i,
    input  logic [WIDTH-1:0]  opnd_b_i,
    input  logic [WIDTH-1:0]  opnd_c_i,
    output logic              ready_o,
    output logic              valid_o,
    output logic              done_o,
    output logic [WIDTH-1:0]  result_r_o,
    output logic [WIDTH-1:0]  result_s_o
);
    import mod_seq_pkg::*;

    logic [PC_W-1:0]  pc;
    uop_line_u        line;
    logic             issue;
    logic             capture;
    logic             prog_end;
    logic             busy;
    logic [WIDTH-1:0] wr_data;
    logic [WIDTH-1:0] rd_data;

    uop_rom u_rom (
        .pc_i   (pc),
        .line_o (line)
    );

    operand_bank #(.WIDTH(WIDTH)) u_opnd (
        .clk       (clk),
        .reset_n   (reset_n),
        .capture_i (capture),
        .opnd_a_i  (opnd_a_i),
        .opnd_b_i  (opnd_b_i),
        .opnd_c_i  (opnd_c_i),
        .line_i    (line),
        .wr_data_o (wr_data)
    );

    uop_sequencer u_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_i),
        .cmd_i      (cmd_i),
        .busy_i     (busy),
        .line_i     (line),
        .pc_o       (pc),
        .issue_o    (issue),
        .capture_o  (capture),
        .prog_end_o (prog_end),
        .ready_o    (ready_o)
    );

    mod_arith_unit #(.WIDTH(WIDTH), .PRIME(PRIME)) u_arith (
        .clk       (clk),
        .reset_n   (reset_n),
        .issue_i   (issue),
        .line_i    (line),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data),
        .busy_o    (busy)
    );

    result_regs #(.WIDTH(WIDTH)) u_res (
        .clk        (clk),
        .reset_n    (reset_n),
        .issue_i    (issue),
        .capture_i  (capture),
        .prog_end_i (prog_end),
        .line_i     (line),
        .rd_data_i  (rd_data),
        .result_r_o (result_r_o),
        .result_s_o (result_s_o),
        .valid_o    (valid_o),
        .done_o     (done_o)
    );

endmodule

// File: tb/tb_mod_seq.sv
// Self-checking testbench for mod_seq_top at WIDTH 16 and PRIME 65521.
// Directed cases come from tb/mod_seq_stimulus.txt, so run from the project root.
// Random operands are drawn below PRIME with a fixed seed.
// Every wait gives up after TIMEOUT cycles and ends the run.
module tb_mod_seq;
    timeunit 1ns;
    timeprecision 100ps;

    import mod_seq_pkg::*;

    localparam int          WIDTH     = 16;
    localparam int unsigned PRIME     = 65521;
    localparam int          TIMEOUT   = 400;
    localparam int          N_RANDOM  = 50;
    localparam logic [31:0] RAND_SEED = 32'h1f12bbba;
    localparam string       STIM_FILE = "tb/mod_seq_stimulus.txt";

    logic             clk;
    logic             reset_n;
    logic             start_i;
    cmd_e             cmd;
    logic [WIDTH-1:0] opnd_a;
    logic [WIDTH-1:0] opnd_b;
    logic [WIDTH-1:0] opnd_c;
    logic             ready_o;
    logic             valid_o;
    logic             done_o;
    logic [WIDTH-1:0] result_r_o;
    logic [WIDTH-1:0] result_s_o;

    int total_errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int done_pulses;
    bit timed_out;

    mod_seq_top #(.WIDTH(WIDTH), .PRIME(PRIME)) dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .start_i    (start_i),
        .cmd_i      (cmd),
        .opnd_a_i   (opnd_a),
        .opnd_b_i   (opnd_b),
        .opnd_c_i   (opnd_c),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .done_o     (done_o),
        .result_r_o (result_r_o),
        .result_s_o (result_s_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // done pulses counted in the middle of the cycle
    always @(negedge clk) begin
        if (done_o === 1'b1) begin
            done_pulses++;
        end
    end

    // ----------------------------------------------------------------------
    // checking and bookkeeping
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s (at %0t ns)", what, $time);
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    // reference model from the command definitions
    function automatic logic [WIDTH-1:0] mod_prime(input longint unsigned v);
        return WIDTH'(v % longint'(PRIME));
    endfunction

    // ----------------------------------------------------------------------
    // stimulus helpers, all entered 1 ns after a rising edge
    // ----------------------------------------------------------------------
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (ready_o !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ready_o !== 1'b1) begin
            report_failure("timeout: ready_o never came back high");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done();
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done_o === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_value("valid_o", valid_o, 32'h0);
            end
        end
        if (!seen) begin
            report_failure("timeout: done_o never pulsed after a start");
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_start(input cmd_e c_cmd, input logic [WIDTH-1:0] a,
                               input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] c);
        cmd     = c_cmd;
        opnd_a  = a;
        opnd_b  = b;
        opnd_c  = c;
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        cmd     = CMD_NONE;
    endtask

    // one full command with result and pulse checks
    task automatic run_case(input cmd_e c_cmd, input logic [WIDTH-1:0] a,
                            input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] c,
                            input logic [WIDTH-1:0] exp_r, input logic [WIDTH-1:0] exp_s);
        wait_ready();
        if (timed_out) begin
            return;
        end
        drive_start(c_cmd, a, b, c);
        check_value("valid_o", valid_o, 32'h0);
        wait_done();
        if (timed_out) begin
            return;
        end
        check_value("result_r_o", result_r_o, exp_r);
        check_value("result_s_o", result_s_o, exp_s);
        check_value("valid_o", valid_o, 32'h1);
        @(posedge clk);
        #1;
        check_value("done_o", done_o, 32'h0);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic run_directed();
        int          fd;
        int          code;
        int          line_no;
        string       text;
        cmd_e        f_kind;
        logic [31:0] f_cmd;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [31:0] f_r;
        logic [31:0] f_s;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            start_test();
            report_failure("could not open the stimulus file");
            end_test("stimulus file");
            return;
        end
        line_no = 0;
        while (!$feof(fd) && !timed_out) begin
            code = $fgets(text, fd);
            if (code == 0) begin
                break;
            end
            line_no++;
            // blank and comment lines
            if (text.len() < 2 || text.substr(0, 0) == "#") begin
                continue;
            end
            start_test();
            code = $sscanf(text, "%h %h %h %h %h %h", f_cmd, f_a, f_b, f_c, f_r, f_s);
            f_kind = cmd_e'(f_cmd[1:0]);
            if (code != 6) begin
                report_failure($sformatf("stimulus line %0d could not be parsed", line_no));
            end else begin
                run_case(f_kind, f_a[WIDTH-1:0], f_b[WIDTH-1:0], f_c[WIDTH-1:0],
                         f_r[WIDTH-1:0], f_s[WIDTH-1:0]);
            end
            end_test($sformatf("directed line %0d %s", line_no, f_kind.name()));
        end
        $fclose(fd);
    endtask

    task automatic run_ignored_starts();
        logic valid_before;
        start_test();
        wait_ready();
        if (!timed_out) begin
            // reserved command is dropped
            valid_before = valid_o;
            drive_start(CMD_RSVD, 16'h0001, 16'h0002, 16'h0003);
            check_value("ready_o", ready_o, 32'h1);
            check_value("valid_o", valid_o, 32'(valid_before));
            // mac 5*6+7, then a square-add while busy
            drive_start(CMD_MAC, 16'h0005, 16'h0006, 16'h0007);
            check_value("ready_o", ready_o, 32'h0);
            drive_start(CMD_SQR_ADD, 16'h0064, 16'h00c8, 16'h0000);
            wait_done();
        end
        if (!timed_out) begin
            check_value("result_r_o", result_r_o, 32'h25);
            check_value("result_s_o", result_s_o, 32'h1e);
            @(posedge clk);
            #1;
            check_value("done_o", done_o, 32'h0);
            check_value("ready_o", ready_o, 32'h1);
        end
        end_test("ignored starts");
    endtask

    task automatic run_random();
        longint unsigned  a;
        longint unsigned  b;
        longint unsigned  c;
        cmd_e             c_cmd;
        logic [WIDTH-1:0] exp_r;
        logic [WIDTH-1:0] exp_s;
        int               pulses_before;
        int               i;
        start_test();
        pulses_before = done_pulses;
        i = 0;
        while (i < N_RANDOM && !timed_out) begin
            a = longint'($urandom % PRIME);
            b = longint'($urandom % PRIME);
            c = longint'($urandom % PRIME);
            if ($urandom % 2 == 0) begin
                c_cmd = CMD_MAC;
                exp_r = mod_prime(a * b + c);
                exp_s = mod_prime(a * b);
            end else begin
                c_cmd = CMD_SQR_ADD;
                exp_r = mod_prime(a * a);
                exp_s = mod_prime(a + b);
            end
            run_case(c_cmd, WIDTH'(a), WIDTH'(b), WIDTH'(c), exp_r, exp_s);
            i++;
        end
        if (!timed_out) begin
            check_value("done pulse count", done_pulses - pulses_before, N_RANDOM);
        end
        end_test($sformatf("random x%0d", N_RANDOM));
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(RAND_SEED));
        total_errors = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_pulses  = 0;
        timed_out    = 1'b0;
        reset_n      = 1'b0;
        start_i      = 1'b0;
        cmd          = CMD_NONE;
        opnd_a       = '0;
        opnd_b       = '0;
        opnd_c       = '0;

        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        start_test();
        check_value("ready_o", ready_o, 32'h1);
        check_value("valid_o", valid_o, 32'h0);
        check_value("done_o", done_o, 32'h0);
        end_test("reset state");

        run_directed();
        if (!timed_out) begin
            run_ignored_starts();
        end
        if (!timed_out) begin
            run_random();
        end

        $display("tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb/mod_seq_stimulus.txt
# columns: cmd a b c expected_r expected_s, all hex, modulus 65521
# cmd 1 is multiply-accumulate, cmd 2 is square-add (c unused)
1 0002 0003 0004 000a 0006
1 0000 1234 0005 0005 0000
1 0001 fff0 0001 0000 fff0
1 fff0 fff0 fff0 0000 0001
1 0100 0100 0003 0012 000f
1 00ff 00ff 0001 fe02 fe01
2 0003 0004 0000 0009 0007
2 fff0 0001 0000 0001 0000
2 0100 fff0 0000 000f 00ff
2 8000 8000 0000 c02d 000f

// File: filelist.f
src/mod_seq_pkg.sv
src/uop_rom.sv
src/operand_bank.sv
src/uop_sequencer.sv
src/mod_arith_unit.sv
src/result_regs.sv
src/mod_seq_top.sv
tb/tb_mod_seq.sv

// File: Makefile
# Verilator build and run for the modular-arithmetic engine testbench.
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mod_seq
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
